//--- cpu_and_dma.f
rtl/z80_bus_pkg.sv
rtl/dma_regs_pkg.sv
rtl/dma_regs.sv
rtl/dma_engine.sv
rtl/bus_arbiter.sv
rtl/cpu_and_dma.sv
sim/tb_bus_model.sv
sim/tb_cpu_and_dma.sv

//--- rtl/bus_arbiter.sv
`timescale 1ns/1ps

module bus_arbiter import z80_bus_pkg::*; (
  input  logic     clk,
  input  logic     reset,
  input  logic     req,
  output logic     grant,
  output logic     busrq_n,
  input  logic     busak_n,
  input  z80_bus_t cpu_bus,
  input  z80_bus_t dma_bus,
  output z80_bus_t bus
);

  logic busrq_n_q;
  logic busak_n_q;
  logic own_q;

  // busrq_n lags req by one cycle both ways
  // busak_n registered before use
  always_ff @(posedge clk) begin
    if (reset) begin
      busrq_n_q <= 1'b1;
      busak_n_q <= 1'b1;
      own_q     <= 1'b0;
    end else begin
      busrq_n_q <= !req;
      busak_n_q <= busak_n;
      // ownership once the registered acknowledge is low
      own_q     <= req && !busak_n_q;
    end
  end

  // drops in the same cycle as req
  // also drops at once if the cpu takes busak_n back
  assign grant   = own_q && req && !busak_n_q;
  assign busrq_n = busrq_n_q;

  // strobe mux
  always_comb begin
    if (grant) begin
      bus      = dma_bus;
      // no opcode fetch while the dma drives
      bus.m1_n = 1'b1;
    end else begin
      bus = cpu_bus;
    end
  end

  // the dma only drives after the cpu has acknowledged
  a_grant_after_busak: assert property (@(posedge clk) disable iff (reset)
    grant |-> $past(!busak_n));

endmodule

//--- rtl/cpu_and_dma.sv
`timescale 1ns/1ps

module cpu_and_dma import z80_bus_pkg::*; import dma_regs_pkg::*; #(
  parameter int count_width = 16
) (
  input  logic       clk,
  input  logic       reset,
  input  wb_req_t    wb_req,
  output wb_rsp_t    wb_rsp,
  input  z80_bus_t   cpu_bus,
  output logic       busrq_n,
  input  logic       busak_n,
  input  logic       wait_n,
  input  logic [7:0] di,
  output z80_bus_t   bus,
  output logic       irq
);

  dma_cfg_t cfg;
  logic     busy;
  logic     done_pulse;
  logic     req;
  logic     grant;
  z80_bus_t dma_bus;

  // host side register file
  dma_regs #(
    .count_width(count_width)
  ) u_dma_regs (
    .clk       (clk),
    .reset     (reset),
    .wb_req    (wb_req),
    .wb_rsp    (wb_rsp),
    .cfg       (cfg),
    .busy      (busy),
    .done_pulse(done_pulse)
  );

  // transfer engine, data comes back on the shared di
  dma_engine #(
    .count_width(count_width)
  ) u_dma_engine (
    .clk       (clk),
    .reset     (reset),
    .cfg       (cfg),
    .di        (di),
    .wait_n    (wait_n),
    .grant     (grant),
    .req       (req),
    .dma_bus   (dma_bus),
    .busy      (busy),
    .done_pulse(done_pulse)
  );

  // cpu handshake and output mux
  bus_arbiter u_bus_arbiter (
    .clk    (clk),
    .reset  (reset),
    .req    (req),
    .grant  (grant),
    .busrq_n(busrq_n),
    .busak_n(busak_n),
    .cpu_bus(cpu_bus),
    .dma_bus(dma_bus),
    .bus    (bus)
  );

  // end of transfer doubles as the interrupt
  assign irq = done_pulse;

endmodule

//--- rtl/dma_engine.sv
`timescale 1ns/1ps

module dma_engine import z80_bus_pkg::*; import dma_regs_pkg::*; #(
  parameter int count_width = 16
) (
  input  logic       clk,
  input  logic       reset,
  input  dma_cfg_t   cfg,
  input  logic [7:0] di,
  input  logic       wait_n,
  input  logic       grant,
  output logic       req,
  output z80_bus_t   dma_bus,
  output logic       busy,
  output logic       done_pulse
);

  typedef enum logic [1:0] {
    ph_idle,
    ph_wait_grant,
    ph_read,
    ph_write
  } dma_phase_e;

  dma_phase_e             phase_q;
  tstate_e                tstate_q;
  logic                   req_q;
  logic                   done_q;
  logic [15:0]            src_q;
  logic [15:0]            dst_q;
  logic [count_width-1:0] cnt_q;
  logic [7:0]             data_q;
  logic                   src_io_q;
  logic                   dst_io_q;
  logic                   src_inc_q;
  logic                   dst_inc_q;
  z80_bus_t               drv;

  // control state
  always_ff @(posedge clk) begin
    if (reset) begin
      phase_q  <= ph_idle;
      tstate_q <= t_idle;
      req_q    <= 1'b0;
      done_q   <= 1'b0;
    end else begin
      done_q <= 1'b0;
      case (phase_q)
        ph_idle: begin
          if (cfg.start) begin
            // zero length finishes here without touching the bus
            if (cfg.len == '0) begin
              done_q <= 1'b1;
            end else begin
              req_q   <= 1'b1;
              phase_q <= ph_wait_grant;
            end
          end
        end
        ph_wait_grant: begin
          if (grant) begin
            phase_q  <= ph_read;
            tstate_q <= t1;
          end
        end
        ph_read, ph_write: begin
          case (tstate_q)
            t1: tstate_q <= t2;
            // wait states stretch t2
            t2: if (wait_n) tstate_q <= t3;
            t3: begin
              tstate_q <= t1;
              if (phase_q == ph_read) begin
                phase_q <= ph_write;
              end else if (cnt_q == count_width'(1)) begin
                // last byte written, hand the bus back
                phase_q  <= ph_idle;
                tstate_q <= t_idle;
                req_q    <= 1'b0;
                done_q   <= 1'b1;
              end else begin
                phase_q <= ph_read;
              end
            end
            default: tstate_q <= t1;
          endcase
        end
        default: phase_q <= ph_idle;
      endcase
    end
  end

  // addresses, count and data byte
  always_ff @(posedge clk) begin
    if (phase_q == ph_idle && cfg.start) begin
      src_q     <= cfg.src;
      dst_q     <= cfg.dst;
      cnt_q     <= cfg.len[count_width-1:0];
      src_io_q  <= cfg.src_io;
      dst_io_q  <= cfg.dst_io;
      src_inc_q <= cfg.src_inc;
      dst_inc_q <= cfg.dst_inc;
    end
    if (tstate_q == t3 && phase_q == ph_read) begin
      // di sampled at the end of t3
      data_q <= di;
      if (src_inc_q) begin
        src_q <= src_q + 16'd1;
      end
    end
    if (tstate_q == t3 && phase_q == ph_write) begin
      cnt_q <= cnt_q - count_width'(1);
      if (dst_inc_q) begin
        dst_q <= dst_q + 16'd1;
      end
    end
  end

  // strobes from phase and t-state
  always_comb begin
    drv = bus_idle;
    case (phase_q)
      ph_read: begin
        drv.a      = src_q;
        drv.mreq_n = src_io_q;
        drv.iorq_n = !src_io_q;
        drv.rd_n   = 1'b0;
      end
      ph_write: begin
        drv.a      = dst_q;
        drv.dout   = data_q;
        drv.mreq_n = dst_io_q;
        drv.iorq_n = !dst_io_q;
        // wr_n follows mreq_n by one clock as on the z80
        drv.wr_n   = (tstate_q == t1);
      end
      default: ;
    endcase
    dma_bus = grant ? drv : bus_idle;
  end

  assign req        = req_q;
  assign busy       = (phase_q != ph_idle);
  assign done_pulse = done_q;

  a_rd_wr_excl: assert property (@(posedge clk) disable iff (reset)
    !(!dma_bus.rd_n && !dma_bus.wr_n));

  // nothing leaks onto the bus before the arbiter hands it over
  a_idle_no_grant: assert property (@(posedge clk) disable iff (reset)
    !grant |-> (dma_bus == bus_idle));

endmodule

//--- rtl/dma_regs.sv
`timescale 1ns/1ps

module dma_regs import dma_regs_pkg::*; #(
  parameter int count_width = 16
) (
  input  logic     clk,
  input  logic     reset,
  input  wb_req_t  wb_req,
  output wb_rsp_t  wb_rsp,
  output dma_cfg_t cfg,
  input  logic     busy,
  input  logic     done_pulse
);

  logic [15:0]            src_q;
  logic [15:0]            dst_q;
  logic [count_width-1:0] len_q;
  logic [15:0]            len_wide;
  logic [3:0]             mode_q;
  logic                   start_q;
  logic                   done_q;
  logic                   ack_q;
  logic                   wr_en;
  dma_reg_e               reg_sel;

  assign reg_sel  = dma_reg_e'(wb_req.adr);
  // length seen as two bytes, bits above count_width read as zero
  assign len_wide = 16'(len_q);
  // writes land on the edge that closes the ack cycle
  assign wr_en    = ack_q && wb_req.cyc && wb_req.stb && wb_req.we;

  // ack one cycle after the request
  // the cycle after ack is dead so the held request is not seen twice
  always_ff @(posedge clk) begin
    if (reset) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= wb_req.cyc && wb_req.stb && !ack_q;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      src_q   <= '0;
      dst_q   <= '0;
      len_q   <= '0;
      mode_q  <= '0;
      start_q <= 1'b0;
      done_q  <= 1'b0;
    end else begin
      // start lives for one cycle only
      start_q <= 1'b0;
      if (wr_en) begin
        case (reg_sel)
          src_lo: src_q[7:0]  <= wb_req.dat;
          src_hi: src_q[15:8] <= wb_req.dat;
          dst_lo: dst_q[7:0]  <= wb_req.dat;
          dst_hi: dst_q[15:8] <= wb_req.dat;
          len_lo: len_q <= count_width'({len_wide[15:8], wb_req.dat});
          len_hi: len_q <= count_width'({wb_req.dat, len_wide[7:0]});
          ctrl: begin
            mode_q  <= wb_req.dat[3:0];
            // a start while a transfer runs is dropped
            start_q <= wb_req.dat[ctrl_start] && !busy;
            done_q  <= 1'b0;
          end
          default: ;
        endcase
      end
      // end of transfer wins over a clearing write in the same cycle
      if (done_pulse) begin
        done_q <= 1'b1;
      end
    end
  end

  // read data only on the ack cycle
  always_comb begin
    wb_rsp.ack = ack_q;
    wb_rsp.dat = 8'h00;
    if (ack_q) begin
      case (reg_sel)
        src_lo: wb_rsp.dat = src_q[7:0];
        src_hi: wb_rsp.dat = src_q[15:8];
        dst_lo: wb_rsp.dat = dst_q[7:0];
        dst_hi: wb_rsp.dat = dst_q[15:8];
        len_lo: wb_rsp.dat = len_wide[7:0];
        len_hi: wb_rsp.dat = len_wide[15:8];
        ctrl:   wb_rsp.dat = {4'b0000, mode_q};
        status: begin
          wb_rsp.dat[status_busy] = busy;
          wb_rsp.dat[status_done] = done_q;
        end
        default: wb_rsp.dat = 8'h00;
      endcase
    end
  end

  assign cfg.src     = src_q;
  assign cfg.dst     = dst_q;
  assign cfg.len     = cfg_len_width'(len_q);
  assign cfg.src_io  = mode_q[ctrl_src_io];
  assign cfg.dst_io  = mode_q[ctrl_dst_io];
  assign cfg.src_inc = mode_q[ctrl_src_inc];
  assign cfg.dst_inc = mode_q[ctrl_dst_inc];
  assign cfg.start   = start_q;
  assign cfg.spare   = 1'b0;

  // every access sees a single ack even when the master keeps stb up
  a_ack_single: assert property (@(posedge clk) disable iff (reset)
    wb_rsp.ack |=> !wb_rsp.ack);

endmodule

//--- rtl/dma_regs_pkg.sv
package dma_regs_pkg;

  // byte-wide register map seen over wishbone
  typedef enum logic [2:0] {
    src_lo = 3'd0,
    src_hi = 3'd1,
    dst_lo = 3'd2,
    dst_hi = 3'd3,
    len_lo = 3'd4,
    len_hi = 3'd5,
    ctrl   = 3'd6,
    status = 3'd7
  } dma_reg_e;

  // ctrl bit positions
  localparam int ctrl_src_io  = 0;
  localparam int ctrl_dst_io  = 1;
  localparam int ctrl_src_inc = 2;
  localparam int ctrl_dst_inc = 3;
  localparam int ctrl_start   = 7;

  // status bit positions
  localparam int status_busy = 0;
  localparam int status_done = 1;

  // two length bytes in the map, so the count never exceeds 16 bits
  localparam int cfg_len_width = 16;

  // wishbone classic, 8-bit data
  typedef struct packed {
    logic       cyc;
    logic       stb;
    logic       we;
    logic [2:0] adr;
    logic [7:0] dat;
  } wb_req_t;

  typedef struct packed {
    logic [7:0] dat;
    logic       ack;
  } wb_rsp_t;

  // transfer setup handed to the engine
  typedef struct packed {
    logic [15:0]              src;
    logic [15:0]              dst;
    logic [cfg_len_width-1:0] len;
    logic                     src_io;
    logic                     dst_io;
    logic                     src_inc;
    logic                     dst_inc;
    logic                     start;
    logic                     spare;
  } dma_cfg_t;

endpackage

//--- rtl/z80_bus_pkg.sv
package z80_bus_pkg;

  // outputs of one bus master
  // all strobes active low as on the z80 pins
  typedef struct packed {
    logic [15:0] a;
    logic [7:0]  dout;
    logic        mreq_n;
    logic        iorq_n;
    logic        rd_n;
    logic        wr_n;
    logic        m1_n;
  } z80_bus_t;

  // released bus with every strobe inactive
  localparam z80_bus_t bus_idle = '{
    a:      16'h0000,
    dout:   8'h00,
    mreq_n: 1'b1,
    iorq_n: 1'b1,
    rd_n:   1'b1,
    wr_n:   1'b1,
    m1_n:   1'b1
  };

  // t-state inside a dma read or write cycle
  // t2 repeats while wait_n is low
  typedef enum logic [1:0] {
    t_idle = 2'd0,
    t1     = 2'd1,
    t2     = 2'd2,
    t3     = 2'd3
  } tstate_e;

endpackage

//--- run_sim.sh
#!/bin/sh
# build and run the DMA testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
  --top-module tb_cpu_and_dma -Mdir obj_dir -f cpu_and_dma.f

./obj_dir/Vtb_cpu_and_dma > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log

if grep -q "SIMULATION FAILED" sim.log; then
  exit 1
fi

//--- sim/tb_bus_model.sv
`timescale 1ns/1ps

module tb_bus_model import z80_bus_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  z80_bus_t   bus,
  input  logic       busrq_n,
  input  logic       wait_en,
  output z80_bus_t   cpu_bus,
  output logic       busak_n,
  output logic       wait_n,
  output logic [7:0] di
);

  // 64 KB memory and every byte written to an io port
  logic [7:0]  mem [0:65535];
  logic [7:0]  io_log [0:255];
  int          io_count;
  logic [31:0] lcg_q;
  int          ack_delay;
  logic        ack_armed;
  logic        waits_on;
  logic        prev_wr_n;
  logic [15:0] cpu_addr;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  initial begin
    for (int i = 0; i < 65536; i++) begin
      // fill mixes both address bytes
      mem[i] = 8'(i ^ (i >> 8) * 7 ^ 32'h5a);
    end
    io_count  = 0;
    lcg_q     = 32'h1ad2_5fd1;
    ack_delay = 0;
    ack_armed = 1'b0;
    waits_on  = 1'b0;
    prev_wr_n = 1'b1;
    cpu_addr  = 16'h0000;
    cpu_bus   = bus_idle;
    busak_n   = 1'b1;
    wait_n    = 1'b1;
    di        = 8'hff;
  end

  always @(posedge clk) begin
    // wait_en was driven after the previous edge
    waits_on = wait_en;
    #2;
    if (reset) begin
      cpu_bus   = bus_idle;
      busak_n   = 1'b1;
      wait_n    = 1'b1;
      ack_armed = 1'b0;
      di        = 8'hff;
    end else begin
      // dma writes, io logged once per wr_n fall
      if (!bus.wr_n && !bus.mreq_n) begin
        mem[bus.a] = bus.dout;
      end
      if (!bus.wr_n && !bus.iorq_n && prev_wr_n) begin
        io_log[io_count[7:0]] = bus.dout;
        io_count = io_count + 1;
      end
      // read data for the current owner
      if (!bus.rd_n && !bus.mreq_n) begin
        di = mem[bus.a];
      end else if (!bus.rd_n && !bus.iorq_n) begin
        di = bus.a[7:0] ^ 8'hc3;
      end else begin
        di = 8'hff;
      end
      // busak_n after 1 to 5 cycles
      if (busrq_n) begin
        busak_n   = 1'b1;
        ack_armed = 1'b0;
      end else if (busak_n && !ack_armed) begin
        lcg_q     = lcg_next(lcg_q);
        ack_delay = 1 + int'(lcg_q[23:16] % 8'd5);
        ack_armed = 1'b1;
      end else if (busak_n) begin
        ack_delay = ack_delay - 1;
        if (ack_delay == 0) begin
          busak_n = 1'b0;
        end
      end
      // random wait states, only honored in t2
      if (waits_on && !busak_n) begin
        lcg_q  = lcg_next(lcg_q);
        wait_n = (lcg_q[25:24] != 2'b00);
      end else begin
        wait_n = 1'b1;
      end
      // cpu streams memory reads while it owns the bus
      cpu_bus = bus_idle;
      if (busak_n) begin
        cpu_addr       = cpu_addr + 16'd1;
        cpu_bus.a      = cpu_addr;
        cpu_bus.mreq_n = 1'b0;
        cpu_bus.rd_n   = 1'b0;
        cpu_bus.m1_n   = (cpu_addr[1:0] != 2'b00);
      end
    end
    prev_wr_n = bus.wr_n;
  end

endmodule

//--- sim/tb_cpu_and_dma.sv
`timescale 1ns/1ps

module tb_cpu_and_dma import z80_bus_pkg::*; import dma_regs_pkg::*; ();

  localparam int count_width = 16;
  localparam int ack_timeout = 20;

  logic       clk;
  logic       reset;
  wb_req_t    wb_req;
  wb_rsp_t    wb_rsp;
  z80_bus_t   cpu_bus;
  logic       busrq_n;
  logic       busak_n;
  logic       wait_n;
  logic [7:0] di;
  z80_bus_t   bus;
  logic       irq;
  logic       wait_en;
  logic       expect_io_dst;
  logic       expect_no_busrq;
  logic       timed_out;
  int         errors;
  // expected memory image and expected io bytes
  logic [7:0] shadow [0:65535];
  logic [7:0] io_expect [$];

  cpu_and_dma #(
    .count_width(count_width)
  ) u_cpu_and_dma (
    .clk    (clk),
    .reset  (reset),
    .wb_req (wb_req),
    .wb_rsp (wb_rsp),
    .cpu_bus(cpu_bus),
    .busrq_n(busrq_n),
    .busak_n(busak_n),
    .wait_n (wait_n),
    .di     (di),
    .bus    (bus),
    .irq    (irq)
  );

  tb_bus_model u_bus_model (
    .clk    (clk),
    .reset  (reset),
    .bus    (bus),
    .busrq_n(busrq_n),
    .wait_en(wait_en),
    .cpu_bus(cpu_bus),
    .busak_n(busak_n),
    .wait_n (wait_n),
    .di     (di)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic report_mismatch(input string msg);
    errors++;
    $display("FAILED %0t: %s", $time, msg);
  endtask

  task automatic report_timeout(input string what);
    errors++;
    timed_out = 1'b1;
    $display("timeout while waiting for %s", what);
  endtask

  // one classic access, entered and left 2 ns after an edge
  task automatic wb_cycle(input logic we, input dma_reg_e idx, input logic [7:0] wdat,
                          output logic [7:0] rdat);
    int n;
    n    = 0;
    rdat = 8'h00;
    if (timed_out) return;
    wb_req.cyc = 1'b1;
    wb_req.stb = 1'b1;
    wb_req.we  = we;
    wb_req.adr = idx;
    wb_req.dat = wdat;
    do begin
      @(posedge clk);
      #2;
      n++;
    end while (!wb_rsp.ack && n < ack_timeout);
    if (!wb_rsp.ack) begin
      report_timeout("the Wishbone ack");
    end else begin
      rdat = wb_rsp.dat;
      // still held here so a write lands on this edge
      @(posedge clk);
      #2;
      // request still up, the slave must not ack it again
      assert (!wb_rsp.ack) else report_mismatch("ack seen twice for one access");
    end
    wb_req = '0;
    // idle cycle between accesses
    @(posedge clk);
    #2;
  endtask

  task automatic wb_write(input dma_reg_e idx, input logic [7:0] wdat);
    logic [7:0] ignored;
    wb_cycle(1'b1, idx, wdat, ignored);
  endtask

  task automatic wb_read(input dma_reg_e idx, output logic [7:0] rdat);
    wb_cycle(1'b0, idx, 8'h00, rdat);
  endtask

  task automatic check_reg(input dma_reg_e idx, input logic [7:0] wdat, input logic [7:0] mask);
    logic [7:0] rdat;
    wb_write(idx, wdat);
    wb_read(idx, rdat);
    assert (rdat == (wdat & mask)) else report_mismatch($sformatf(
      "register %0d read %h, expected %h", idx, rdat, wdat & mask));
  endtask

  task automatic wait_irq(input int max_cycles);
    int n;
    n = 0;
    if (timed_out) return;
    while (!irq && n < max_cycles) begin
      @(posedge clk);
      #2;
      n++;
    end
    if (!irq) report_timeout("the end of the transfer");
  endtask

  task automatic check_memory;
    int bad;
    int first;
    bad   = 0;
    first = 0;
    for (int a = 0; a < 65536; a++) begin
      if (u_bus_model.mem[a] !== shadow[a]) begin
        if (bad == 0) first = a;
        bad++;
      end
    end
    assert (bad == 0) else report_mismatch($sformatf(
      "%0d memory bytes differ, first at %h", bad, first));
  endtask

  task automatic check_io_log(input int start);
    assert (u_bus_model.io_count == start + io_expect.size()) else report_mismatch(
      $sformatf("io log holds %0d bytes, expected %0d", u_bus_model.io_count - start,
                io_expect.size()));
    foreach (io_expect[i]) begin
      assert (u_bus_model.io_log[8'(start + i)] == io_expect[i]) else report_mismatch(
        $sformatf("io byte %0d is %h, expected %h", i, u_bus_model.io_log[8'(start + i)],
                  io_expect[i]));
    end
  endtask

  // program, start, wait for done and compare everything
  task automatic run_transfer(input logic [15:0] src, input logic [15:0] dst,
                              input logic [15:0] len, input logic [3:0] mode,
                              input logic waits, input logic restart);
    int         io_start;
    int         s;
    int         d;
    logic [7:0] st;
    wait_en       = waits;
    expect_io_dst = mode[ctrl_dst_io];
    io_start      = u_bus_model.io_count;
    io_expect.delete();
    // byte after byte, the way the copy is defined
    s = int'(src);
    d = int'(dst);
    for (int i = 0; i < int'(len); i++) begin
      if (mode[ctrl_dst_io]) begin
        io_expect.push_back(shadow[16'(s)]);
      end else begin
        shadow[16'(d)] = shadow[16'(s)];
      end
      if (mode[ctrl_src_inc]) s++;
      if (mode[ctrl_dst_inc]) d++;
    end
    wb_write(src_lo, src[7:0]);
    wb_write(src_hi, src[15:8]);
    wb_write(dst_lo, dst[7:0]);
    wb_write(dst_hi, dst[15:8]);
    wb_write(len_lo, len[7:0]);
    wb_write(len_hi, len[15:8]);
    wb_write(ctrl, {4'b1000, mode});
    if (restart) begin
      wb_read(status, st);
      assert (st[status_busy]) else report_mismatch("busy not set during the transfer");
      // second start in the middle of the copy
      wb_write(ctrl, {4'b1000, mode});
    end
    wait_irq(200 + 100 * int'(len));
    if (!timed_out) begin
      // busrq_n follows req one cycle later
      @(posedge clk);
      #2;
      assert (busrq_n) else report_mismatch("busrq_n still low after done");
    end
    wb_read(status, st);
    assert (st == 8'h02) else report_mismatch($sformatf("status %h after done", st));
    if (restart) begin
      for (int i = 0; i < 30; i++) begin
        @(posedge clk);
        #2;
        assert (!irq && busrq_n) else report_mismatch("transfer restarted by a busy start");
      end
    end
    check_memory();
    if (mode[ctrl_dst_io]) check_io_log(io_start);
    wait_en       = 1'b0;
    expect_io_dst = 1'b0;
  endtask

  task automatic finish_run;
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  endtask

  // bus ownership rules, sampled mid-cycle
  always @(negedge clk) begin
    if (!reset) begin
      if (busak_n) begin
        assert (bus == cpu_bus) else report_mismatch($sformatf(
          "bus %h differs from cpu_bus %h", bus, cpu_bus));
      end
      if (u_cpu_and_dma.grant) begin
        assert (bus.m1_n) else report_mismatch("m1_n low during dma ownership");
        assert (!busak_n) else report_mismatch("grant without busak_n low");
      end
      if (u_cpu_and_dma.grant && !bus.wr_n) begin
        if (expect_io_dst) begin
          assert (!bus.iorq_n && bus.mreq_n) else report_mismatch("io write without iorq_n");
        end else begin
          assert (!bus.mreq_n && bus.iorq_n) else report_mismatch("memory write without mreq_n");
        end
      end
      if (expect_no_busrq) begin
        assert (busrq_n) else report_mismatch("busrq_n low for a zero length transfer");
      end
    end
  end

  initial begin
    reset           = 1'b1;
    wb_req          = '0;
    wait_en         = 1'b0;
    expect_io_dst   = 1'b0;
    expect_no_busrq = 1'b0;
    timed_out       = 1'b0;
    errors          = 0;
    repeat (16) @(posedge clk);
    #2;
    reset = 1'b0;
    for (int a = 0; a < 65536; a++) begin
      shadow[a] = u_bus_model.mem[a];
    end
    // register read back, ctrl keeps its mode bits, status is read only
    check_reg(src_lo, 8'h34, 8'hff);
    check_reg(src_hi, 8'h12, 8'hff);
    check_reg(dst_lo, 8'hcd, 8'hff);
    check_reg(dst_hi, 8'hab, 8'hff);
    check_reg(len_lo, 8'h78, 8'hff);
    check_reg(len_hi, 8'h56, 8'hff);
    check_reg(ctrl, 8'h3a, 8'h0f);
    check_reg(status, 8'hff, 8'h00);
    // memory to memory, both sides stepping
    run_transfer(16'h1000, 16'h8000, 16'd16, 4'b1100, 1'b0, 1'b0);
    // memory to one io port
    run_transfer(16'h2000, 16'h0042, 16'd6, 4'b0110, 1'b0, 1'b0);
    // random wait states and a start while busy
    run_transfer(16'h3000, 16'h9000, 16'd12, 4'b1100, 1'b1, 1'b1);
    // zero length never asks for the bus
    expect_no_busrq = 1'b1;
    run_transfer(16'h4000, 16'ha000, 16'd0, 4'b1100, 1'b0, 1'b0);
    expect_no_busrq = 1'b0;
    finish_run();
  end

endmodule
